// File: include/mmu_cfg.svh
// ----------------------------------------------------------------------
// SV39 data MMU configuration
// address widths, TLB sizing, privilege codes and page fault causes
// ----------------------------------------------------------------------

`ifndef MMU_CFG_SVH
`define MMU_CFG_SVH

// ----------------------------------------------------------------------
// address widths
// ----------------------------------------------------------------------
// virtual address, SV39
`define MMU_VLEN 39
// physical address
`define MMU_PLEN 56
// physical page number
`define MMU_PPNW 44
// virtual page number, three 9 bit fields
`define MMU_VPNW 27
// width of the exception value
`define MMU_XLEN 64

// ----------------------------------------------------------------------
// data TLB
// ----------------------------------------------------------------------
// number of fully associative entries
`define MMU_TLB_ENTRIES 4
// width of an entry index, must cover MMU_TLB_ENTRIES
`define MMU_TLB_IDXW 2

// ----------------------------------------------------------------------
// privilege levels and exception causes
// ----------------------------------------------------------------------
`define MMU_PRIV_U 2'd0
`define MMU_PRIV_S 2'd1
// load and store page faults as in the privileged spec
`define MMU_CAUSE_LOAD_PF 64'd13
`define MMU_CAUSE_STORE_PF 64'd15

`endif

// File: hw/mmu_pkg.sv
// ----------------------------------------------------------------------
// MMU types
// page table entry word, read flat or split into the leaf PPN fields
// ----------------------------------------------------------------------

`include "mmu_cfg.svh"

package mmu_pkg;

  // one SV39 page table entry, 64 bits in both views
  typedef union packed {
    // whole PPN, as the TLB stores and returns it
    struct packed {
      logic [9:0]           reserved;
      logic [`MMU_PPNW-1:0] ppn;
      // bits kept for software
      logic [1:0]           rsw;
      logic                 d;
      logic                 a;
      logic                 g;
      logic                 u;
      logic                 x;
      logic                 w;
      logic                 r;
      logic                 v;
    } flat;
    // PPN split per level so superpage bits can be replaced
    struct packed {
      logic [9:0]  reserved;
      logic [25:0] ppn2;
      logic [8:0]  ppn1;
      logic [8:0]  ppn0;
      logic [1:0]  rsw;
      logic [7:0]  flags;
    } leaf;
  } pte_u;

endpackage

// File: hw/tlb_refill.sv
// ----------------------------------------------------------------------
// data TLB refill control
// picks the victim entry and drives one write enable per entry
// ----------------------------------------------------------------------

`include "mmu_cfg.svh"

module tlb_refill (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        flush_i,
  input  logic                        refill_valid_i,
  input  logic [`MMU_TLB_ENTRIES-1:0] entry_valid_i,
  output logic [`MMU_TLB_ENTRIES-1:0] entry_we_o
);

  // round robin pointer, only used once every entry is valid
  logic [`MMU_TLB_IDXW-1:0] rr_q;
  logic [`MMU_TLB_IDXW-1:0] victim;
  logic                     all_valid;

  assign all_valid = &entry_valid_i;

  // lowest free entry wins, else fall back to the pointer
  always_comb begin
    victim = rr_q;
    // walk downwards so the lowest invalid index is the last one kept
    for (int i = `MMU_TLB_ENTRIES - 1; i >= 0; i--) begin
      if (!entry_valid_i[i]) begin
        victim = i[`MMU_TLB_IDXW-1:0];
      end
    end
  end

  // flush has priority over a refill in the same cycle
  always_comb begin
    entry_we_o = '0;
    if (refill_valid_i && !flush_i) begin
      entry_we_o[victim] = 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // replacement pointer
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q <= '0;
    end else if (flush_i) begin
      rr_q <= '0;
    end else if (refill_valid_i && all_valid) begin
      // advance only on an evicting refill, wrap at the entry count
      if (int'(rr_q) == `MMU_TLB_ENTRIES - 1) begin
        rr_q <= '0;
      end else begin
        rr_q <= rr_q + 1'b1;
      end
    end
  end

  // at most one entry is ever written per cycle
  assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(entry_we_o))
    else $error("tlb_refill: more than one entry write enable");

endmodule

// File: hw/tlb_entry.sv
// ----------------------------------------------------------------------
// data TLB entry
// holds tag, page size and PTE, matches the lookup VPN per page size
// ----------------------------------------------------------------------

`include "mmu_cfg.svh"

module tlb_entry import mmu_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  input  logic                 we_i,
  input  logic [`MMU_VPNW-1:0] refill_vpn_i,
  input  pte_u                 refill_pte_i,
  input  logic                 refill_is_2m_i,
  input  logic                 refill_is_1g_i,
  input  logic [`MMU_VPNW-1:0] lu_vpn_i,
  output logic                 valid_o,
  output logic                 match_o,
  output pte_u                 pte_o,
  output logic                 is_2m_o,
  output logic                 is_1g_o
);

  logic                 valid_q;
  logic [`MMU_VPNW-1:0] vpn_q;
  pte_u                 pte_q;
  logic                 is_2m_q;
  logic                 is_1g_q;

  // per level compare, vpn2 is 26:18, vpn1 17:9, vpn0 8:0
  logic vpn2_eq;
  logic vpn1_eq;
  logic vpn0_eq;

  assign vpn2_eq = (lu_vpn_i[26:18] == vpn_q[26:18]);
  assign vpn1_eq = (lu_vpn_i[17:9] == vpn_q[17:9]);
  assign vpn0_eq = (lu_vpn_i[8:0] == vpn_q[8:0]);

  // 1G ignores vpn1 and vpn0, 2M ignores vpn0
  assign match_o = valid_q && vpn2_eq && (is_1g_q || (vpn1_eq && (is_2m_q || vpn0_eq)));

  assign valid_o = valid_q;
  assign pte_o   = pte_q;
  assign is_2m_o = is_2m_q;
  assign is_1g_o = is_1g_q;

  // ----------------------------------------------------------------------
  // storage
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (we_i) begin
      valid_q <= 1'b1;
    end
  end

  // tag and payload
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      vpn_q   <= refill_vpn_i;
      pte_q   <= refill_pte_i;
      is_2m_q <= refill_is_2m_i;
      is_1g_q <= refill_is_1g_i;
    end
  end

  // a live entry has exactly one page size
  assert property (@(posedge clk_i) disable iff (!rst_ni) valid_q |-> !(is_2m_q && is_1g_q))
    else $error("tlb_entry: entry marked both 2M and 1G");

endmodule

// File: hw/tlb_hit_select.sv
// ----------------------------------------------------------------------
// data TLB hit select
// reduces the entry matches to one hit with its PTE and page size
// ----------------------------------------------------------------------

`include "mmu_cfg.svh"

module tlb_hit_select import mmu_pkg::*; #(
  parameter int unsigned N = `MMU_TLB_ENTRIES
) (
  input  logic [N-1:0] match_i,
  input  pte_u [N-1:0] pte_i,
  input  logic [N-1:0] is_2m_i,
  input  logic [N-1:0] is_1g_i,
  output logic         hit_o,
  output pte_u         pte_o,
  output logic         is_2m_o,
  output logic         is_1g_o
);

  assign hit_o = |match_i;

  // matches are one-hot, so a priority mux picks the single hit
  always_comb begin
    pte_o   = '0;
    is_2m_o = 1'b0;
    is_1g_o = 1'b0;
    for (int i = 0; i < N; i++) begin
      if (match_i[i]) begin
        pte_o   = pte_i[i];
        is_2m_o = is_2m_i[i];
        is_1g_o = is_1g_i[i];
      end
    end
  end

  // ----------------------------------------------------------------------
  // checks
  // ----------------------------------------------------------------------
  // two entries covering one VPN means a refill wrote a duplicate
  always_comb begin
    if (!$isunknown(match_i)) begin
      assert final ($onehot0(match_i))
        else $error("tlb_hit_select: multiple entries match one VPN");
    end
  end

endmodule

// File: hw/dtlb_translate.sv
// ----------------------------------------------------------------------
// data address translation stage
// cycle 0 hit and PPN, cycle 1 physical address and page faults
// ----------------------------------------------------------------------

`include "mmu_cfg.svh"

module dtlb_translate import mmu_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 en_ld_st_translation_i,
  input  logic                 lsu_req_i,
  input  logic [`MMU_VLEN-1:0] lsu_vaddr_i,
  input  logic                 lsu_is_store_i,
  input  logic [1:0]           ld_st_priv_lvl_i,
  input  logic                 sum_i,
  input  logic                 tlb_hit_i,
  input  pte_u                 tlb_pte_i,
  input  logic                 tlb_is_2m_i,
  input  logic                 tlb_is_1g_i,
  output logic                 lsu_dtlb_hit_o,
  output logic [`MMU_PPNW-1:0] lsu_dtlb_ppn_o,
  output logic                 dtlb_miss_o,
  output logic                 lsu_valid_o,
  output logic [`MMU_PLEN-1:0] lsu_paddr_o,
  output logic                 lsu_ex_valid_o,
  output logic [63:0]          lsu_ex_cause_o,
  output logic [`MMU_XLEN-1:0] lsu_ex_tval_o
);

  // superpages take the low PPN fields from the virtual address
  function automatic logic [`MMU_PPNW-1:0] leaf_ppn(input pte_u pte,
                                                    input logic [`MMU_VLEN-1:0] vaddr,
                                                    input logic is_2m,
                                                    input logic is_1g);
    pte_u p;
    p = pte;
    if (is_2m || is_1g) begin
      p.leaf.ppn0 = vaddr[20:12];
    end
    if (is_1g) begin
      p.leaf.ppn1 = vaddr[29:21];
    end
    return p.flat.ppn;
  endfunction

  // request stage, control
  logic                 req_q;
  logic                 en_q;
  logic                 hit_q;
  // request stage, payload
  logic [`MMU_VLEN-1:0] vaddr_q;
  logic                 is_store_q;
  logic [1:0]           priv_q;
  logic                 sum_q;
  pte_u                 pte_q;
  logic                 is_2m_q;
  logic                 is_1g_q;

  logic                 access_err;
  logic                 fault;

  // ----------------------------------------------------------------------
  // cycle 0
  // ----------------------------------------------------------------------
  // without translation every request is ready at once
  assign lsu_dtlb_hit_o = en_ld_st_translation_i ? tlb_hit_i : 1'b1;
  assign lsu_dtlb_ppn_o = en_ld_st_translation_i ?
                          leaf_ppn(tlb_pte_i, lsu_vaddr_i, tlb_is_2m_i, tlb_is_1g_i) :
                          `MMU_PPNW'(lsu_vaddr_i[`MMU_VLEN-1:12]);
  // perf counter pulse
  assign dtlb_miss_o    = lsu_req_i && en_ld_st_translation_i && !tlb_hit_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q <= 1'b0;
      en_q  <= 1'b0;
      hit_q <= 1'b0;
    end else begin
      req_q <= lsu_req_i;
      en_q  <= en_ld_st_translation_i;
      hit_q <= tlb_hit_i;
    end
  end

  always_ff @(posedge clk_i) begin
    vaddr_q    <= lsu_vaddr_i;
    is_store_q <= lsu_is_store_i;
    priv_q     <= ld_st_priv_lvl_i;
    sum_q      <= sum_i;
    pte_q      <= tlb_pte_i;
    is_2m_q    <= tlb_is_2m_i;
    is_1g_q    <= tlb_is_1g_i;
  end

  // ----------------------------------------------------------------------
  // cycle 1
  // ----------------------------------------------------------------------
  // a miss stays silent until the requester refills and retries
  assign lsu_valid_o = req_q && (!en_q || hit_q);
  assign lsu_paddr_o = en_q ? {leaf_ppn(pte_q, vaddr_q, is_2m_q, is_1g_q), vaddr_q[11:0]} :
                              `MMU_PLEN'(vaddr_q);

  // S mode needs SUM for user pages, U mode needs a user page
  assign access_err = ((priv_q == `MMU_PRIV_S) && !sum_q && pte_q.flat.u) ||
                      ((priv_q == `MMU_PRIV_U) && !pte_q.flat.u);
  // stores also need write permission and a set dirty bit
  assign fault = is_store_q ? (!pte_q.flat.w || !pte_q.flat.d || access_err) : access_err;

  assign lsu_ex_valid_o = req_q && en_q && hit_q && fault;
  assign lsu_ex_cause_o = !lsu_ex_valid_o ? 64'd0 :
                          is_store_q ? `MMU_CAUSE_STORE_PF : `MMU_CAUSE_LOAD_PF;
  // tval is the faulting vaddr, sign extended
  assign lsu_ex_tval_o  = !lsu_ex_valid_o ? '0 :
                          {{(`MMU_XLEN - `MMU_VLEN){vaddr_q[`MMU_VLEN-1]}}, vaddr_q};

  // permission checks only know U and S, any other level would pass unchecked
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   lsu_req_i && en_ld_st_translation_i |->
                   ld_st_priv_lvl_i inside {`MMU_PRIV_U, `MMU_PRIV_S})
    else $error("dtlb_translate: translated request with unsupported privilege");

endmodule

// File: hw/dtlb_mmu.sv
// ----------------------------------------------------------------------
// data MMU top level
// fully associative data TLB with refill control and translate stage
// ----------------------------------------------------------------------

`include "mmu_cfg.svh"

module dtlb_mmu import mmu_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  // refill from outside, one cycle strobe
  input  logic                 refill_valid_i,
  input  logic [`MMU_VLEN-1:0] refill_vaddr_i,
  input  pte_u                 refill_pte_i,
  input  logic                 refill_is_2m_i,
  input  logic                 refill_is_1g_i,
  // load/store request
  input  logic                 en_ld_st_translation_i,
  input  logic                 lsu_req_i,
  input  logic [`MMU_VLEN-1:0] lsu_vaddr_i,
  input  logic                 lsu_is_store_i,
  input  logic [1:0]           ld_st_priv_lvl_i,
  input  logic                 sum_i,
  // cycle 0
  output logic                 lsu_dtlb_hit_o,
  output logic [`MMU_PPNW-1:0] lsu_dtlb_ppn_o,
  output logic                 dtlb_miss_o,
  // cycle 1
  output logic                 lsu_valid_o,
  output logic [`MMU_PLEN-1:0] lsu_paddr_o,
  output logic                 lsu_ex_valid_o,
  output logic [63:0]          lsu_ex_cause_o,
  output logic [`MMU_XLEN-1:0] lsu_ex_tval_o
);

  logic [`MMU_TLB_ENTRIES-1:0] entry_we;
  logic [`MMU_TLB_ENTRIES-1:0] entry_valid;
  logic [`MMU_TLB_ENTRIES-1:0] entry_match;
  pte_u [`MMU_TLB_ENTRIES-1:0] entry_pte;
  logic [`MMU_TLB_ENTRIES-1:0] entry_is_2m;
  logic [`MMU_TLB_ENTRIES-1:0] entry_is_1g;

  logic tlb_hit;
  pte_u tlb_pte;
  logic tlb_is_2m;
  logic tlb_is_1g;

  tlb_refill i_refill (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .flush_i        ( flush_i        ),
    .refill_valid_i ( refill_valid_i ),
    .entry_valid_i  ( entry_valid    ),
    .entry_we_o     ( entry_we       )
  );

  // ----------------------------------------------------------------------
  // entries, all looked up with the request VPN
  // ----------------------------------------------------------------------
  for (genvar i = 0; i < `MMU_TLB_ENTRIES; i++) begin : g_entry
    tlb_entry i_entry (
      .clk_i          ( clk_i                     ),
      .rst_ni         ( rst_ni                    ),
      .flush_i        ( flush_i                   ),
      .we_i           ( entry_we[i]               ),
      .refill_vpn_i   ( refill_vaddr_i[38:12]     ),
      .refill_pte_i   ( refill_pte_i              ),
      .refill_is_2m_i ( refill_is_2m_i            ),
      .refill_is_1g_i ( refill_is_1g_i            ),
      .lu_vpn_i       ( lsu_vaddr_i[38:12]        ),
      .valid_o        ( entry_valid[i]            ),
      .match_o        ( entry_match[i]            ),
      .pte_o          ( entry_pte[i]              ),
      .is_2m_o        ( entry_is_2m[i]            ),
      .is_1g_o        ( entry_is_1g[i]            )
    );
  end

  tlb_hit_select #(
    .N ( `MMU_TLB_ENTRIES )
  ) i_hit_select (
    .match_i ( entry_match ),
    .pte_i   ( entry_pte   ),
    .is_2m_i ( entry_is_2m ),
    .is_1g_i ( entry_is_1g ),
    .hit_o   ( tlb_hit     ),
    .pte_o   ( tlb_pte     ),
    .is_2m_o ( tlb_is_2m   ),
    .is_1g_o ( tlb_is_1g   )
  );

  dtlb_translate i_translate (
    .clk_i                  ( clk_i                  ),
    .rst_ni                 ( rst_ni                 ),
    .en_ld_st_translation_i ( en_ld_st_translation_i ),
    .lsu_req_i              ( lsu_req_i              ),
    .lsu_vaddr_i            ( lsu_vaddr_i            ),
    .lsu_is_store_i         ( lsu_is_store_i         ),
    .ld_st_priv_lvl_i       ( ld_st_priv_lvl_i       ),
    .sum_i                  ( sum_i                  ),
    .tlb_hit_i              ( tlb_hit                ),
    .tlb_pte_i              ( tlb_pte                ),
    .tlb_is_2m_i            ( tlb_is_2m              ),
    .tlb_is_1g_i            ( tlb_is_1g              ),
    .lsu_dtlb_hit_o         ( lsu_dtlb_hit_o         ),
    .lsu_dtlb_ppn_o         ( lsu_dtlb_ppn_o         ),
    .dtlb_miss_o            ( dtlb_miss_o            ),
    .lsu_valid_o            ( lsu_valid_o            ),
    .lsu_paddr_o            ( lsu_paddr_o            ),
    .lsu_ex_valid_o         ( lsu_ex_valid_o         ),
    .lsu_ex_cause_o         ( lsu_ex_cause_o         ),
    .lsu_ex_tval_o          ( lsu_ex_tval_o          )
  );

endmodule

// File: tb/tb_dtlb_mmu.sv
// ----------------------------------------------------------------------
// data MMU testbench
// table driven refills, lookups and flushes with cycle 0 and cycle 1
// checks against values worked out from the SV39 translation rules
// ----------------------------------------------------------------------

`include "mmu_cfg.svh"

module tb_dtlb_mmu import mmu_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  typedef enum logic [1:0] {op_refill, op_lookup, op_flush} op_e;

  // page sizes as kept in the table
  localparam logic [1:0] sz_4k = 2'd0;
  localparam logic [1:0] sz_2m = 2'd1;
  localparam logic [1:0] sz_1g = 2'd2;

  localparam logic [1:0] priv_u = `MMU_PRIV_U;
  localparam logic [1:0] priv_s = `MMU_PRIV_S;

  // one table row, stimulus first, then expected responses
  typedef struct {
    op_e                  op;
    logic [`MMU_VLEN-1:0] vaddr;
    pte_u                 pte;
    logic [1:0]           size;
    logic                 is_store;
    logic [1:0]           priv;
    logic                 sum;
    logic                 en;
    logic                 exp_hit;
    logic                 exp_miss;
    logic [`MMU_PPNW-1:0] exp_ppn;
    logic                 exp_valid;
    logic [`MMU_PLEN-1:0] exp_paddr;
    logic                 exp_ex;
    logic [63:0]          exp_cause;
    logic [`MMU_XLEN-1:0] exp_tval;
  } row_t;

  logic                 clk_i;
  logic                 rst_ni;
  logic                 flush_i;
  logic                 refill_valid_i;
  logic [`MMU_VLEN-1:0] refill_vaddr_i;
  pte_u                 refill_pte_i;
  logic                 refill_is_2m_i;
  logic                 refill_is_1g_i;
  logic                 en_ld_st_translation_i;
  logic                 lsu_req_i;
  logic [`MMU_VLEN-1:0] lsu_vaddr_i;
  logic                 lsu_is_store_i;
  logic [1:0]           ld_st_priv_lvl_i;
  logic                 sum_i;
  logic                 lsu_dtlb_hit_o;
  logic [`MMU_PPNW-1:0] lsu_dtlb_ppn_o;
  logic                 dtlb_miss_o;
  logic                 lsu_valid_o;
  logic [`MMU_PLEN-1:0] lsu_paddr_o;
  logic                 lsu_ex_valid_o;
  logic [63:0]          lsu_ex_cause_o;
  logic [`MMU_XLEN-1:0] lsu_ex_tval_o;

  row_t        rows[$];
  int unsigned cycle_count = 0;
  int unsigned cycle_limit = 0;

  dtlb_mmu dut_i (.*);

  // 40 ns period
  always #20 clk_i = ~clk_i;

  // ----------------------------------------------------------------------
  // failure handling and compare tasks
  // ----------------------------------------------------------------------
  task automatic abort_run();
    $display("TB FAILED");
    $fatal(1);
  endtask

  // watchdog, limit follows the table length
  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
      $display("timeout: run still busy after %0d clock cycles", cycle_count);
      abort_run();
    end
  end

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0d ns: %s is %b, expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_paddr(input logic [`MMU_PLEN-1:0] got,
                             input logic [`MMU_PLEN-1:0] exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0d ns: %s is %h, expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_ppn(input logic [`MMU_PPNW-1:0] got,
                           input logic [`MMU_PPNW-1:0] exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0d ns: %s is %h, expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_cause(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_tval(input logic [`MMU_XLEN-1:0] got,
                            input logic [`MMU_XLEN-1:0] exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0d ns: %s is %h, expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  // ----------------------------------------------------------------------
  // table building
  // ----------------------------------------------------------------------
  function automatic logic [`MMU_VLEN-1:0] va(input logic [8:0] vpn2, input logic [8:0] vpn1,
                                              input logic [8:0] vpn0, input logic [11:0] off);
    return {vpn2, vpn1, vpn0, off};
  endfunction

  function automatic logic [8:0] rnd9();
    return 9'($urandom());
  endfunction

  function automatic logic [11:0] rnd12();
    return 12'($urandom());
  endfunction

  // readable, accessed leaf with the given user, write and dirty bits
  function automatic pte_u make_pte(input logic [`MMU_PPNW-1:0] ppn, input logic u,
                                    input logic w, input logic d);
    pte_u p;
    p = '0;
    p.flat.ppn = ppn;
    p.flat.v   = 1'b1;
    p.flat.r   = 1'b1;
    p.flat.a   = 1'b1;
    p.flat.u   = u;
    p.flat.w   = w;
    p.flat.d   = d;
    return p;
  endfunction

  function automatic void add_refill(input logic [`MMU_VLEN-1:0] vaddr, input pte_u pte,
                                     input logic [1:0] size);
    row_t r;
    r = '{op: op_refill, default: '0};
    r.vaddr = vaddr;
    r.pte   = pte;
    r.size  = size;
    rows.push_back(r);
  endfunction

  function automatic void add_flush();
    row_t r;
    r = '{op: op_flush, default: '0};
    rows.push_back(r);
  endfunction

  // pte and size describe the entry expected to hit, hit is the expected lookup result
  function automatic void add_lookup(input logic [`MMU_VLEN-1:0] vaddr, input pte_u pte,
                                     input logic [1:0] size, input logic is_store,
                                     input logic [1:0] priv, input logic sum,
                                     input logic en, input logic hit);
    row_t r;
    logic user_ok;
    r = '{op: op_lookup, default: '0};
    r.vaddr    = vaddr;
    r.pte      = pte;
    r.size     = size;
    r.is_store = is_store;
    r.priv     = priv;
    r.sum      = sum;
    r.en       = en;
    if (!en) begin
      // bare mode, always ready and never faulting
      r.exp_hit   = 1'b1;
      r.exp_valid = 1'b1;
      r.exp_paddr = `MMU_PLEN'(vaddr);
    end else if (hit) begin
      r.exp_hit   = 1'b1;
      r.exp_valid = 1'b1;
      case (size)
        sz_2m:   r.exp_paddr = {pte.flat.ppn[43:9], vaddr[20:0]};
        sz_1g:   r.exp_paddr = {pte.flat.ppn[43:18], vaddr[29:0]};
        default: r.exp_paddr = {pte.flat.ppn, vaddr[11:0]};
      endcase
      r.exp_ppn = r.exp_paddr[`MMU_PLEN-1:12];
      // U mode only on user pages, S mode on user pages only with SUM
      user_ok = (priv == priv_u) ? pte.flat.u : (!pte.flat.u || sum);
      r.exp_ex = is_store ? (!pte.flat.w || !pte.flat.d || !user_ok) : !user_ok;
      r.exp_cause = is_store ? 64'd15 : 64'd13;
      r.exp_tval  = `MMU_XLEN'($signed(vaddr));
    end else begin
      r.exp_miss = 1'b1;
    end
    rows.push_back(r);
  endfunction

  task automatic build_table();
    pte_u pte_a;
    pte_u pte_b;
    pte_u pte_c;
    pte_u pte_d;
    pte_u pte_e;
    pte_a = make_pte(44'h000_0012_3456, 1'b0, 1'b1, 1'b1);
    pte_b = make_pte(44'h0ab_cde1_2345, 1'b1, 1'b1, 1'b0);
    pte_c = make_pte(44'h003_1415_9265, 1'b0, 1'b0, 1'b1);
    pte_d = make_pte(44'h000_0000_0d0d, 1'b1, 1'b1, 1'b1);
    pte_e = make_pte(44'h7ff_0000_0777, 1'b0, 1'b1, 1'b1);
    // bare mode before any refill
    add_lookup(va(9'h1a5, rnd9(), rnd9(), rnd12()), '0, sz_4k, 1'b0, priv_s, 1'b0, 1'b0, 1'b1);
    // 4K supervisor page, load then store back to back
    add_refill(va(9'd1, 9'd2, 9'd3, 12'h0), pte_a, sz_4k);
    add_lookup(va(9'd1, 9'd2, 9'd3, rnd12()), pte_a, sz_4k, 1'b0, priv_s, 1'b0, 1'b1, 1'b1);
    add_lookup(va(9'd1, 9'd2, 9'd3, rnd12()), pte_a, sz_4k, 1'b1, priv_s, 1'b0, 1'b1, 1'b1);
    // 2M user page with d clear
    add_refill(va(9'd5, 9'd7, 9'd0, 12'h0), pte_b, sz_2m);
    add_lookup(va(9'd5, 9'd7, rnd9(), rnd12()), pte_b, sz_2m, 1'b0, priv_s, 1'b0, 1'b1, 1'b1);
    add_lookup(va(9'd5, 9'd7, rnd9(), rnd12()), pte_b, sz_2m, 1'b0, priv_s, 1'b1, 1'b1, 1'b1);
    add_lookup(va(9'd5, 9'd7, rnd9(), rnd12()), pte_b, sz_2m, 1'b1, priv_u, 1'b0, 1'b1, 1'b1);
    add_lookup(va(9'd5, 9'd7, rnd9(), rnd12()), pte_b, sz_2m, 1'b0, priv_u, 1'b0, 1'b1, 1'b1);
    // 1G read-only supervisor page, top vaddr bit set for the tval sign
    add_refill(va(9'h1f0, 9'd0, 9'd0, 12'h0), pte_c, sz_1g);
    add_lookup(va(9'h1f0, rnd9(), rnd9(), rnd12()), pte_c, sz_1g, 1'b0, priv_u, 1'b0, 1'b1, 1'b1);
    add_lookup(va(9'h1f0, rnd9(), rnd9(), rnd12()), pte_c, sz_1g, 1'b1, priv_s, 1'b0, 1'b1, 1'b1);
    add_lookup(va(9'h1f0, rnd9(), rnd9(), rnd12()), pte_c, sz_1g, 1'b0, priv_s, 1'b0, 1'b1, 1'b1);
    // unknown VPN
    add_lookup(va(9'd100, rnd9(), rnd9(), rnd12()), '0, sz_4k, 1'b0, priv_s, 1'b0, 1'b1, 1'b0);
    // fourth refill fills the TLB, fifth one evicts entry 0
    add_refill(va(9'd20, 9'd1, 9'd1, 12'h0), pte_d, sz_4k);
    add_lookup(va(9'd20, 9'd1, 9'd1, rnd12()), pte_d, sz_4k, 1'b1, priv_u, 1'b0, 1'b1, 1'b1);
    add_refill(va(9'd30, 9'd4, 9'd4, 12'h0), pte_e, sz_4k);
    add_lookup(va(9'd1, 9'd2, 9'd3, rnd12()), '0, sz_4k, 1'b0, priv_s, 1'b0, 1'b1, 1'b0);
    add_lookup(va(9'd30, 9'd4, 9'd4, rnd12()), pte_e, sz_4k, 1'b0, priv_s, 1'b0, 1'b1, 1'b1);
    add_lookup(va(9'd5, 9'd7, rnd9(), rnd12()), pte_b, sz_2m, 1'b0, priv_s, 1'b1, 1'b1, 1'b1);
    // flush drops every entry
    add_flush();
    add_lookup(va(9'd5, 9'd7, rnd9(), rnd12()), '0, sz_4k, 1'b0, priv_s, 1'b0, 1'b1, 1'b0);
    add_lookup(va(9'h1f0, rnd9(), rnd9(), rnd12()), '0, sz_4k, 1'b0, priv_s, 1'b0, 1'b1, 1'b0);
    add_lookup(va(9'd20, 9'd1, 9'd1, rnd12()), '0, sz_4k, 1'b0, priv_s, 1'b0, 1'b1, 1'b0);
    add_lookup(va(9'd30, 9'd4, 9'd4, rnd12()), '0, sz_4k, 1'b0, priv_s, 1'b0, 1'b1, 1'b0);
    // entries are usable again after the flush
    add_refill(va(9'd1, 9'd2, 9'd3, 12'h0), pte_a, sz_4k);
    add_lookup(va(9'd1, 9'd2, 9'd3, rnd12()), pte_a, sz_4k, 1'b0, priv_s, 1'b0, 1'b1, 1'b1);
    // bare mode store in U mode, high address bit passes through
    add_lookup(va(9'h1ff, rnd9(), rnd9(), rnd12()), '0, sz_4k, 1'b1, priv_u, 1'b0, 1'b0, 1'b1);
  endtask

  // ----------------------------------------------------------------------
  // driving and checking
  // ----------------------------------------------------------------------
  task automatic drive_row(input row_t r);
    flush_i                = (r.op == op_flush);
    refill_valid_i         = (r.op == op_refill);
    lsu_req_i              = (r.op == op_lookup);
    refill_vaddr_i         = r.vaddr;
    refill_pte_i           = r.pte;
    refill_is_2m_i         = (r.size == sz_2m);
    refill_is_1g_i         = (r.size == sz_1g);
    // lookup address only moves on lookups
    if (r.op == op_lookup) begin
      lsu_vaddr_i            = r.vaddr;
      lsu_is_store_i         = r.is_store;
      ld_st_priv_lvl_i       = r.priv;
      sum_i                  = r.sum;
      en_ld_st_translation_i = r.en;
    end
  endtask

  // combinational results in the request cycle
  task automatic check_lookup(input row_t r, input int idx);
    check_bit(lsu_dtlb_hit_o, r.exp_hit, $sformatf("row %0d cycle 0 hit", idx));
    check_bit(dtlb_miss_o, r.exp_miss, $sformatf("row %0d miss pulse", idx));
    if (r.en && r.exp_hit) begin
      check_ppn(lsu_dtlb_ppn_o, r.exp_ppn, $sformatf("row %0d cycle 0 ppn", idx));
    end
  endtask

  // registered results one cycle later, idle rows expect nothing
  task automatic check_response(input row_t r, input int idx);
    logic exp_valid;
    logic exp_ex;
    exp_valid = (r.op == op_lookup) && r.exp_valid;
    exp_ex    = (r.op == op_lookup) && r.exp_ex;
    check_bit(lsu_valid_o, exp_valid, $sformatf("row %0d cycle 1 valid", idx));
    check_bit(lsu_ex_valid_o, exp_ex, $sformatf("row %0d exception valid", idx));
    if (exp_valid) begin
      check_paddr(lsu_paddr_o, r.exp_paddr, $sformatf("row %0d paddr", idx));
    end
    if (exp_ex) begin
      check_cause(lsu_ex_cause_o, r.exp_cause, $sformatf("row %0d cause", idx));
      check_tval(lsu_ex_tval_o, r.exp_tval, $sformatf("row %0d tval", idx));
    end
  endtask

  initial begin
    clk_i                  = 1'b0;
    rst_ni                 = 1'b0;
    flush_i                = 1'b0;
    refill_valid_i         = 1'b0;
    refill_vaddr_i         = '0;
    refill_pte_i           = '0;
    refill_is_2m_i         = 1'b0;
    refill_is_1g_i         = 1'b0;
    en_ld_st_translation_i = 1'b0;
    lsu_req_i              = 1'b0;
    lsu_vaddr_i            = '0;
    lsu_is_store_i         = 1'b0;
    ld_st_priv_lvl_i       = priv_s;
    sum_i                  = 1'b0;
    void'($urandom(67152));
    build_table();
    cycle_limit = rows.size() * 3 + 20;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    // outputs quiet out of reset
    check_bit(lsu_valid_o, 1'b0, "valid after reset");
    check_bit(lsu_ex_valid_o, 1'b0, "exception after reset");
    check_bit(dtlb_miss_o, 1'b0, "miss pulse after reset");
    for (int i = 0; i < rows.size(); i++) begin
      @(negedge clk_i);
      if (i > 0) begin
        check_response(rows[i-1], i - 1);
      end
      drive_row(rows[i]);
      // quarter period settle for the cycle 0 outputs
      #10;
      if (rows[i].op == op_lookup) begin
        check_lookup(rows[i], i);
      end
    end
    @(negedge clk_i);
    check_response(rows[rows.size()-1], rows.size() - 1);
    flush_i        = 1'b0;
    refill_valid_i = 1'b0;
    lsu_req_i      = 1'b0;
    $display("TB PASSED");
    $finish;
  end

endmodule

// File: project.f
+incdir+include
hw/mmu_pkg.sv
hw/tlb_refill.sv
hw/tlb_entry.sv
hw/tlb_hit_select.sv
hw/dtlb_translate.sv
hw/dtlb_mmu.sv
tb/tb_dtlb_mmu.sv

// File: Bender.yml
package:
  name: dtlb_mmu

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/mmu_pkg.sv
      - hw/tlb_refill.sv
      - hw/tlb_entry.sv
      - hw/tlb_hit_select.sv
      - hw/dtlb_translate.sv
      - hw/dtlb_mmu.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_dtlb_mmu.sv
